// File: lcd_panel.f
rtl/display_pkg.sv
rtl/board_pkg.sv
rtl/lcd_scan_if.sv
rtl/lcd_timing.sv
rtl/pixel_fifo.sv
rtl/lcd_output.sv
rtl/backlight_pwm.sv
rtl/home_button.sv
rtl/lcd_panel.sv
test/tb_lcd_panel.sv

// File: Makefile
# Verilator simulation of the LCD panel display.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP ?= tb_lcd_panel
FILELIST ?= lcd_panel.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= sim passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Result: PASS" || (echo "Result: FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_lcd_panel.sv
/* Testbench for the LCD panel display.
   Credit based pixel producer, scan and pixel models, backlight and button checks. */
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_panel;
    import display_pkg::*;
    import board_pkg::*;

    // Small panel of 22 ticks by 8 lines.
    localparam int WIDTH = 16;
    localparam int HEIGHT = 4;
    localparam int H_FP = 2;
    localparam int H_SW = 2;
    localparam int H_BP = 2;
    localparam int V_FP = 1;
    localparam int V_SW = 2;
    localparam int V_BP = 1;
    localparam int LINE_TICKS = WIDTH + H_FP + H_SW + H_BP;
    localparam int FRAME_LINES = HEIGHT + V_FP + V_SW + V_BP;
    // Two clock_50 cycles per tick.
    localparam int FRAME_CYCLES = 2 * LINE_TICKS * FRAME_LINES;
    localparam int FIFO_DEPTH = 8;
    localparam int PRESCALE = 2;
    localparam int STEPS = 10;
    localparam int PWM_PERIOD = PRESCALE * STEPS;
    localparam int PWM_RUNS = 8;
    localparam int DEBOUNCE = 8;
    // Synchronizer, debounce and latch delay with margin.
    localparam int SETTLE = DEBOUNCE + 6;
    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    // Six frames of scan, then the backlight and button phases, with margin.
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 8 * FRAME_CYCLES
        + PWM_RUNS * (PWM_PERIOD + 8) + 10 * (2 * SETTLE);

    logic clock_50 = 1'b0;
    logic reset;
    logic [PIXEL_BITS-1:0] pixel_data;
    logic pixel_valid;
    logic pixel_credit;
    logic frame_start;
    logic underrun;
    logic [COLOR_BITS-1:0] lcd_red;
    logic [COLOR_BITS-1:0] lcd_green;
    logic [COLOR_BITS-1:0] lcd_blue;
    logic lcd_clk;
    logic lcd_de;
    logic lcd_hs_n;
    logic lcd_vs_n;
    logic [PWM_BITS-1:0] brightness;
    logic brightness_valid;
    logic lcd_pwm;
    logic home_button_n;
    logic home_ack;
    logic home_state;

    integer seed = 76;
    logic producer_on;
    // Every pixel the DUT has taken, in order.
    logic [PIXEL_BITS-1:0] pixel_q[$];
    logic pushed_now;
    logic credit_seen;
    int credits;
    int pushes;
    int returned;
    // Scan model state.
    int pop_count;
    int frames_seen;
    int samples;
    int de_samples;
    int hs_low_samples;
    int vs_low_samples;

    lcd_panel #(
        .H_ACTIVE(WIDTH),
        .H_FRONT(H_FP),
        .H_SYNC(H_SW),
        .H_BACK(H_BP),
        .V_ACTIVE(HEIGHT),
        .V_FRONT(V_FP),
        .V_SYNC(V_SW),
        .V_BACK(V_BP),
        .PIXEL_FIFO_DEPTH(FIFO_DEPTH),
        .PWM_PRESCALE(PRESCALE),
        .PWM_MAX(STEPS),
        .DEBOUNCE_CYCLES(DEBOUNCE)
    ) uut (
        .clock_50(clock_50),
        .reset(reset),
        .pixel_data(pixel_data),
        .pixel_valid(pixel_valid),
        .pixel_credit(pixel_credit),
        .frame_start(frame_start),
        .underrun(underrun),
        .lcd_red(lcd_red),
        .lcd_green(lcd_green),
        .lcd_blue(lcd_blue),
        .lcd_clk(lcd_clk),
        .lcd_de(lcd_de),
        .lcd_hs_n(lcd_hs_n),
        .lcd_vs_n(lcd_vs_n),
        .brightness(brightness),
        .brightness_valid(brightness_valid),
        .lcd_pwm(lcd_pwm),
        .home_button_n(home_button_n),
        .home_ack(home_ack),
        .home_state(home_state)
    );

    // 50 MHz.
    always #(CLOCK_PERIOD / 2) clock_50 = ~clock_50;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Waits, then looks at the latched button state.
    task automatic check_home_after(input int cycles, input logic expected);
        repeat (cycles) @(posedge clock_50);
        @(negedge clock_50);
        check_value("home_state", 32'(expected), 32'(home_state));
    endtask

    // One full PWM period of samples after the new level settles.
    task automatic measure_pwm(input logic valid, input int level);
        int high_count;
        int expected;
        high_count = 0;
        @(posedge clock_50);
        brightness_valid <= valid;
        brightness <= PWM_BITS'(level);
        repeat (3) @(posedge clock_50);
        repeat (PWM_PERIOD) begin
            @(negedge clock_50);
            if (lcd_pwm) begin
                high_count++;
            end
        end
        // Invalid means full brightness.
        if (!valid || level >= STEPS) begin
            expected = PWM_PERIOD;
        end else begin
            expected = level * PRESCALE;
        end
        check_value("lcd_pwm_high_cycles", expected, high_count);
    endtask

    // Pixel producer.
    // Spends one credit per push, gets one back per credit pulse.
    initial begin
        int draw;
        pixel_valid <= 1'b0;
        pixel_data <= '0;
        pushed_now = 1'b0;
        credits = FIFO_DEPTH;
        pushes = 0;
        returned = 0;
        forever begin
            @(posedge clock_50);
            // Push the DUT takes at this edge.
            pushed_now = pixel_valid;
            if (pixel_valid) begin
                pixel_q.push_back(pixel_data);
            end
            if (credit_seen) begin
                credits++;
                returned++;
            end
            draw = 0;
            if (producer_on && credits > 0) begin
                draw = $random(seed);
            end
            if (draw[1:0] != 2'b00) begin
                pixel_valid <= 1'b1;
                pixel_data <= PIXEL_BITS'($random(seed));
                credits--;
                pushes++;
            end else begin
                pixel_valid <= 1'b0;
            end
            check_value("credits_in_range", 32'd1,
                        32'(credits >= 0 && credits <= FIFO_DEPTH));
            check_value("pixels_outstanding", 32'd1, 32'(pushes - returned <= FIFO_DEPTH));
        end
    end

    // Panel side model.
    // Samples each new panel pixel while lcd_clk is high.
    initial begin
        int avail;
        credit_seen = 1'b0;
        pop_count = 0;
        frames_seen = 0;
        samples = 0;
        de_samples = 0;
        hs_low_samples = 0;
        vs_low_samples = 0;
        forever begin
            @(negedge clock_50);
            credit_seen = pixel_credit;
            if (lcd_clk) begin
                samples++;
                if (!lcd_hs_n) begin
                    hs_low_samples++;
                end
                if (!lcd_vs_n) begin
                    vs_low_samples++;
                end
                if (lcd_de) begin
                    de_samples++;
                    // A pixel taken at this same edge is not yet poppable.
                    avail = pixel_q.size() - pop_count - int'(pushed_now);
                    if (avail > 0) begin
                        check_value("lcd_rgb", 32'(pixel_q[pop_count]),
                                    32'({lcd_red, lcd_green, lcd_blue}));
                        pop_count++;
                    end else begin
                        check_value("lcd_rgb", 32'd0, 32'({lcd_red, lcd_green, lcd_blue}));
                        check_value("underrun", 32'd1, 32'(underrun));
                    end
                end
            end
            // Last sample of the old frame coincides with the pulse.
            if (frame_start) begin
                if (frames_seen > 0) begin
                    check_value("samples_per_frame", LINE_TICKS * FRAME_LINES, samples);
                    check_value("lcd_de_samples", WIDTH * HEIGHT, de_samples);
                    check_value("lcd_hs_n_low_samples", H_SW * FRAME_LINES, hs_low_samples);
                    check_value("lcd_vs_n_low_samples", V_SW * LINE_TICKS, vs_low_samples);
                end
                samples = 0;
                de_samples = 0;
                hs_low_samples = 0;
                vs_low_samples = 0;
                frames_seen++;
            end
        end
    end

    // Main sequence.
    initial begin
        int mark;
        int level;
        int glitch_len;
        reset <= 1'b1;
        producer_on <= 1'b0;
        brightness <= '0;
        brightness_valid <= 1'b0;
        home_button_n <= 1'b1;
        home_ack <= 1'b0;
        repeat (RESET_CYCLES / 2) @(posedge clock_50);
        @(negedge clock_50);
        check_value("lcd_de", 32'd0, 32'(lcd_de));
        check_value("pixel_credit", 32'd0, 32'(pixel_credit));
        check_value("frame_start", 32'd0, 32'(frame_start));
        check_value("underrun", 32'd0, 32'(underrun));
        check_value("lcd_pwm", 32'd0, 32'(lcd_pwm));
        check_value("home_state", 32'd0, 32'(home_state));
        check_value("lcd_hs_n", 32'd1, 32'(lcd_hs_n));
        check_value("lcd_vs_n", 32'd1, 32'(lcd_vs_n));
        repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clock_50);
        reset <= 1'b0;
        producer_on <= 1'b1;

        // Three full frames with the producer running.
        wait (frames_seen >= 4);
        // The producer keeps the FIFO ahead of the scan.
        check_value("underrun", 32'd0, 32'(underrun));
        @(posedge clock_50);
        producer_on <= 1'b0;
        mark = frames_seen;
        // One frame to drain, one frame of black.
        wait (frames_seen >= mark + 2);
        @(negedge clock_50);
        check_value("underrun", 32'd1, 32'(underrun));
        check_value("pixels_left", 32'd0, pixel_q.size() - pop_count);
        // One credit came back for every pixel shown.
        check_value("credits_returned", pop_count, returned);

        // Backlight.
        for (int i = 0; i < PWM_RUNS - 3; i++) begin
            level = int'({$random(seed)} % (STEPS + 2));
            measure_pwm(1'b1, level);
        end
        measure_pwm(1'b1, 0);
        measure_pwm(1'b1, STEPS);
        measure_pwm(1'b0, 0);

        // Short glitches never pass the debouncer.
        for (int i = 0; i < 4; i++) begin
            glitch_len = 1 + int'({$random(seed)} % (DEBOUNCE - 1));
            @(posedge clock_50);
            home_button_n <= 1'b0;
            repeat (glitch_len) @(posedge clock_50);
            home_button_n <= 1'b1;
            check_home_after(SETTLE, 1'b0);
        end

        // State equals ack, so the press goes through.
        @(posedge clock_50);
        home_button_n <= 1'b0;
        check_home_after(SETTLE, 1'b1);
        // Release waits for the ack.
        @(posedge clock_50);
        home_button_n <= 1'b1;
        check_home_after(SETTLE, 1'b1);
        @(posedge clock_50);
        home_ack <= 1'b1;
        check_home_after(3, 1'b0);
        // Second press waits for the next ack.
        @(posedge clock_50);
        home_button_n <= 1'b0;
        check_home_after(SETTLE, 1'b0);
        @(posedge clock_50);
        home_ack <= 1'b0;
        check_home_after(3, 1'b1);

        @(negedge clock_50);
        $display("sim passed");
        $finish;
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog timeout after %0d cycles, the test did not finish.",
                 WATCHDOG_CYCLES);
        $display("sim failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: rtl/lcd_panel.sv
/* LCD panel display top level.
   Scan timing, pixel FIFO, output stage, backlight and home button. */
`timescale 1ns/1ps
`default_nettype none

module lcd_panel #(
    parameter int H_ACTIVE = display_pkg::H_ACTIVE,
    parameter int H_FRONT = display_pkg::H_FRONT,
    parameter int H_SYNC = display_pkg::H_SYNC,
    parameter int H_BACK = display_pkg::H_BACK,
    parameter int V_ACTIVE = display_pkg::V_ACTIVE,
    parameter int V_FRONT = display_pkg::V_FRONT,
    parameter int V_SYNC = display_pkg::V_SYNC,
    parameter int V_BACK = display_pkg::V_BACK,
    parameter int PIXEL_FIFO_DEPTH = display_pkg::PIXEL_FIFO_DEPTH,
    parameter int PWM_PRESCALE = board_pkg::PWM_PRESCALE,
    parameter int PWM_MAX = board_pkg::PWM_MAX,
    parameter int DEBOUNCE_CYCLES = board_pkg::DEBOUNCE_CYCLES
) (
    input wire clock_50,
    input wire reset,
    // Pixel producer.
    input wire [display_pkg::PIXEL_BITS-1:0] pixel_data,
    input wire pixel_valid,
    output logic pixel_credit,
    output logic frame_start,
    output logic underrun,
    // Panel pins.
    output logic [display_pkg::COLOR_BITS-1:0] lcd_red,
    output logic [display_pkg::COLOR_BITS-1:0] lcd_green,
    output logic [display_pkg::COLOR_BITS-1:0] lcd_blue,
    output logic lcd_clk,
    output logic lcd_de,
    output logic lcd_hs_n,
    output logic lcd_vs_n,
    // Backlight.
    input wire [board_pkg::PWM_BITS-1:0] brightness,
    input wire brightness_valid,
    output logic lcd_pwm,
    // Home button.
    input wire home_button_n,
    input wire home_ack,
    output logic home_state
);
    import display_pkg::*;

    // FIFO head to the output stage.
    logic [PIXEL_BITS-1:0] color;

    lcd_scan_if scan ();

    assign frame_start = scan.frame_start;

    lcd_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK)
    ) lcd_timing_i (
        .clock_50(clock_50),
        .reset(reset),
        .scan(scan)
    );

    pixel_fifo #(
        .PIXEL_FIFO_DEPTH(PIXEL_FIFO_DEPTH)
    ) pixel_fifo_i (
        .clock_50(clock_50),
        .reset(reset),
        .pixel_data(pixel_data),
        .pixel_valid(pixel_valid),
        .pixel_credit(pixel_credit),
        .scan(scan),
        .color(color),
        .underrun(underrun)
    );

    lcd_output lcd_output_i (
        .clock_50(clock_50),
        .reset(reset),
        .scan(scan),
        .color(color),
        .lcd_red(lcd_red),
        .lcd_green(lcd_green),
        .lcd_blue(lcd_blue),
        .lcd_clk(lcd_clk),
        .lcd_de(lcd_de),
        .lcd_hs_n(lcd_hs_n),
        .lcd_vs_n(lcd_vs_n)
    );

    backlight_pwm #(
        .PWM_PRESCALE(PWM_PRESCALE),
        .PWM_MAX(PWM_MAX)
    ) backlight_pwm_i (
        .clock_50(clock_50),
        .reset(reset),
        .brightness(brightness),
        .brightness_valid(brightness_valid),
        .lcd_pwm(lcd_pwm)
    );

    home_button #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) home_button_i (
        .clock_50(clock_50),
        .reset(reset),
        .home_button_n(home_button_n),
        .home_ack(home_ack),
        .home_state(home_state)
    );

endmodule

`default_nettype wire

// File: rtl/home_button.sv
/* Home button debouncer.
   Holds each debounced level until the host echoes the previous one. */
`timescale 1ns/1ps
`default_nettype none

module home_button #(
    parameter int DEBOUNCE_CYCLES = board_pkg::DEBOUNCE_CYCLES
) (
    input wire clock_50,
    input wire reset,
    input wire home_button_n,
    input wire home_ack,
    output logic home_state
);
    import board_pkg::*;

    localparam logic [DEBOUNCE_BITS-1:0] STABLE_LAST = DEBOUNCE_BITS'(DEBOUNCE_CYCLES - 1);

    logic [1:0] button_sync;
    // Raw pin is active low.
    logic pressed;
    logic debounced;
    logic [DEBOUNCE_BITS-1:0] stable_count;

    assign pressed = !button_sync[1];

    // Synchronizer and stability counter.
    always_ff @(posedge clock_50) begin
        if (reset) begin
            button_sync <= 2'b11;
            stable_count <= '0;
            debounced <= 1'b0;
        end else begin
            button_sync <= {button_sync[0], home_button_n};
            if (pressed == debounced) begin
                stable_count <= '0;
            end else if (stable_count == STABLE_LAST) begin
                // Enough identical samples.
                debounced <= pressed;
                stable_count <= '0;
            end else begin
                stable_count <= stable_count + 1'b1;
            end
        end
    end

    // Acknowledge latch.
    // Waits while the host has not echoed the current state.
    always_ff @(posedge clock_50) begin
        if (reset) begin
            home_state <= 1'b0;
        end else if (home_state == home_ack) begin
            home_state <= debounced;
        end
    end

endmodule

`default_nettype wire

// File: rtl/backlight_pwm.sv
/* Backlight PWM.
   Prescaled step counter compared with the host brightness. */
`timescale 1ns/1ps
`default_nettype none

module backlight_pwm #(
    parameter int PWM_PRESCALE = board_pkg::PWM_PRESCALE,
    parameter int PWM_MAX = board_pkg::PWM_MAX
) (
    input wire clock_50,
    input wire reset,
    input wire [board_pkg::PWM_BITS-1:0] brightness,
    input wire brightness_valid,
    output logic lcd_pwm
);
    import board_pkg::*;

    localparam int PRESCALE_BITS = (PWM_PRESCALE > 1) ? $clog2(PWM_PRESCALE) : 1;
    localparam logic [PRESCALE_BITS-1:0] PRESCALE_LAST = PRESCALE_BITS'(PWM_PRESCALE - 1);
    localparam logic [PWM_BITS-1:0] STEP_LAST = PWM_BITS'(PWM_MAX - 1);
    localparam logic [PWM_BITS-1:0] FULL_LEVEL = PWM_BITS'(PWM_MAX);

    logic [PRESCALE_BITS-1:0] prescale_count;
    // One cycle strobe per PWM step.
    logic step;
    logic [PWM_BITS-1:0] step_count;
    logic [PWM_BITS-1:0] level;

    assign step = prescale_count == PRESCALE_LAST;

    // Full brightness until the host sets a value.
    assign level = brightness_valid ? brightness : FULL_LEVEL;

    always_ff @(posedge clock_50) begin
        if (reset) begin
            prescale_count <= '0;
            step_count <= '0;
            lcd_pwm <= 1'b0;
        end else begin
            prescale_count <= step ? '0 : prescale_count + 1'b1;
            if (step) begin
                step_count <= (step_count == STEP_LAST) ? '0 : step_count + 1'b1;
            end
            // High for level steps per period.
            // 0 stays low, PWM_MAX and above stay high.
            lcd_pwm <= step_count < level;
        end
    end

endmodule

`default_nettype wire

// File: rtl/lcd_output.sv
/* LCD output stage.
   Registers color, panel clock, data enable and syncs on each tick. */
`timescale 1ns/1ps
`default_nettype none

module lcd_output (
    input wire clock_50,
    input wire reset,
    lcd_scan_if.out scan,
    input wire [display_pkg::PIXEL_BITS-1:0] color,
    output logic [display_pkg::COLOR_BITS-1:0] lcd_red,
    output logic [display_pkg::COLOR_BITS-1:0] lcd_green,
    output logic [display_pkg::COLOR_BITS-1:0] lcd_blue,
    output logic lcd_clk,
    output logic lcd_de,
    output logic lcd_hs_n,
    output logic lcd_vs_n
);
    import display_pkg::*;

    // Black outside the visible area.
    logic [PIXEL_BITS-1:0] shown;

    assign shown = scan.data_enable ? color : '0;

    always_ff @(posedge clock_50) begin
        if (reset) begin
            lcd_clk <= 1'b0;
            lcd_de <= 1'b0;
            lcd_hs_n <= 1'b1;
            lcd_vs_n <= 1'b1;
            lcd_red <= '0;
            lcd_green <= '0;
            lcd_blue <= '0;
        end else begin
            // Panel clock rises with the new data.
            lcd_clk <= scan.tick;
            if (scan.tick) begin
                lcd_de <= scan.data_enable;
                lcd_hs_n <= scan.hs_n;
                lcd_vs_n <= scan.vs_n;
                lcd_red <= shown[PIXEL_BITS-1 -: COLOR_BITS];
                lcd_green <= shown[PIXEL_BITS-COLOR_BITS-1 -: COLOR_BITS];
                lcd_blue <= shown[COLOR_BITS-1:0];
            end
        end
    end

    // Blanking never carries color.
    blank_is_black: assert property (
        @(posedge clock_50) disable iff (reset)
        !lcd_de |-> {lcd_red, lcd_green, lcd_blue} == '0
    );

endmodule

`default_nettype wire

// File: rtl/pixel_fifo.sv
/* Pixel FIFO between the producer and the scan.
   Pops on active ticks, returns one credit per pop, flags underrun. */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
    parameter int PIXEL_FIFO_DEPTH = display_pkg::PIXEL_FIFO_DEPTH
) (
    input wire clock_50,
    input wire reset,
    input wire [display_pkg::PIXEL_BITS-1:0] pixel_data,
    input wire pixel_valid,
    output logic pixel_credit,
    lcd_scan_if.fifo scan,
    output logic [display_pkg::PIXEL_BITS-1:0] color,
    output logic underrun
);
    import display_pkg::*;

    localparam int PTR_BITS = (PIXEL_FIFO_DEPTH > 1) ? $clog2(PIXEL_FIFO_DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(PIXEL_FIFO_DEPTH + 1);
    localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(PIXEL_FIFO_DEPTH - 1);
    localparam logic [COUNT_BITS-1:0] COUNT_FULL = COUNT_BITS'(PIXEL_FIFO_DEPTH);

    // Circular store.
    logic [PIXEL_BITS-1:0] mem [PIXEL_FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [COUNT_BITS-1:0] fill;
    logic empty;
    logic full;
    // Tick that needs a pixel.
    logic pop_slot;
    logic pop;

    assign empty = fill == '0;
    assign full = fill == COUNT_FULL;
    assign pop_slot = scan.tick && scan.data_enable;
    assign pop = pop_slot && !empty;

    // Credit goes back in the pop cycle.
    assign pixel_credit = pop;

    // Head of the FIFO or black while empty.
    assign color = empty ? '0 : mem[rd_ptr];

    always_ff @(posedge clock_50) begin
        if (pixel_valid) begin
            mem[wr_ptr] <= pixel_data;
        end
    end

    always_ff @(posedge clock_50) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            underrun <= 1'b0;
        end else begin
            if (pixel_valid) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({pixel_valid, pop})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // Sticky until reset.
            if (pop_slot && empty) begin
                underrun <= 1'b1;
            end
        end
    end

    // Producer keeps to its credits.
    no_push_when_full: assert property (
        @(posedge clock_50) disable iff (reset) full |-> !pixel_valid
    );

endmodule

`default_nettype wire

// File: rtl/lcd_timing.sv
/* LCD timing generator.
   Half rate panel tick, scan counters, syncs, data enable and frame start. */
`timescale 1ns/1ps
`default_nettype none

module lcd_timing #(
    parameter int H_ACTIVE = display_pkg::H_ACTIVE,
    parameter int H_FRONT = display_pkg::H_FRONT,
    parameter int H_SYNC = display_pkg::H_SYNC,
    parameter int H_BACK = display_pkg::H_BACK,
    parameter int V_ACTIVE = display_pkg::V_ACTIVE,
    parameter int V_FRONT = display_pkg::V_FRONT,
    parameter int V_SYNC = display_pkg::V_SYNC,
    parameter int V_BACK = display_pkg::V_BACK
) (
    input wire clock_50,
    input wire reset,
    lcd_scan_if.timing scan
);
    import display_pkg::*;

    // Whole line and frame.
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam logic [COORD_BITS-1:0] H_LAST = COORD_BITS'(H_TOTAL - 1);
    localparam logic [COORD_BITS-1:0] V_LAST = COORD_BITS'(V_TOTAL - 1);
    localparam logic [COORD_BITS-1:0] X_ACTIVE = COORD_BITS'(H_ACTIVE);
    localparam logic [COORD_BITS-1:0] Y_ACTIVE = COORD_BITS'(V_ACTIVE);
    // Sync windows follow the front porches.
    localparam logic [COORD_BITS-1:0] HS_START = COORD_BITS'(H_ACTIVE + H_FRONT);
    localparam logic [COORD_BITS-1:0] HS_END = COORD_BITS'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [COORD_BITS-1:0] VS_START = COORD_BITS'(V_ACTIVE + V_FRONT);
    localparam logic [COORD_BITS-1:0] VS_END = COORD_BITS'(V_ACTIVE + V_FRONT + V_SYNC);

    logic x_wrap;
    logic y_wrap;

    assign x_wrap = scan.x == H_LAST;
    assign y_wrap = scan.y == V_LAST;

    // 25 MHz tick.
    // Low in the first cycle out of reset.
    always_ff @(posedge clock_50) begin
        if (reset) begin
            scan.tick <= 1'b0;
        end else begin
            scan.tick <= ~scan.tick;
        end
    end

    // Counters start at the top of vertical blanking.
    // Gives the producer a blanking period to fill the FIFO.
    always_ff @(posedge clock_50) begin
        if (reset) begin
            scan.x <= '0;
            scan.y <= Y_ACTIVE;
            scan.frame_start <= 1'b0;
        end else begin
            // Marks the cycle in which the scan sits at 0,0.
            scan.frame_start <= scan.tick && x_wrap && y_wrap;
            if (scan.tick) begin
                if (x_wrap) begin
                    scan.x <= '0;
                    scan.y <= y_wrap ? '0 : scan.y + 1'b1;
                end else begin
                    scan.x <= scan.x + 1'b1;
                end
            end
        end
    end

    // Visible area.
    assign scan.data_enable = (scan.x < X_ACTIVE) && (scan.y < Y_ACTIVE);

    // Sync pulses.
    assign scan.hs_n = !((scan.x >= HS_START) && (scan.x < HS_END));
    assign scan.vs_n = !((scan.y >= VS_START) && (scan.y < VS_END));

    // Horizontal position stays inside one line.
    x_within_line: assert property (
        @(posedge clock_50) disable iff (reset) int'(scan.x) < H_TOTAL
    );

endmodule

`default_nettype wire

// File: rtl/lcd_scan_if.sv
/* LCD scan interface.
   Carries the tick, counters and sync state from the timing generator. */
`timescale 1ns/1ps
`default_nettype none

interface lcd_scan_if;
    import display_pkg::*;

    // Panel tick, one clock_50 cycle in two.
    logic tick;
    // Current scan position.
    logic [COORD_BITS-1:0] x;
    logic [COORD_BITS-1:0] y;
    // Visible area.
    logic data_enable;
    // Active low syncs.
    logic hs_n;
    logic vs_n;
    // One cycle pulse at the frame wrap.
    logic frame_start;

    modport timing (output tick, x, y, data_enable, hs_n, vs_n, frame_start);
    modport fifo (input tick, data_enable);
    modport out (input tick, data_enable, hs_n, vs_n);

endinterface

`default_nettype wire

// File: rtl/board_pkg.sv
/* Board constants package.
   Clock derived settings for the backlight PWM and the home button. */
`default_nettype none

package board_pkg;

    // 50 MHz / 250 / 1000 gives a 200 Hz backlight.
    localparam int PWM_PRESCALE = 250;
    localparam int PWM_MAX = 1000;
    // Brightness word width.
    localparam int PWM_BITS = 10;

    // 10 ms of stable samples at 50 MHz.
    localparam int DEBOUNCE_CYCLES = 500_000;
    // Stability counter width.
    localparam int DEBOUNCE_BITS = 20;

endpackage

`default_nettype wire

// File: rtl/display_pkg.sv
/* Display geometry package.
   Panel size, porches, sync widths and pixel word layout for the RGB LCD. */
`default_nettype none

package display_pkg;

    // Bits per color channel.
    localparam int COLOR_BITS = 8;
    // One RGB pixel word.
    // Red in the high byte, green in the middle, blue low.
    localparam int PIXEL_BITS = 3 * COLOR_BITS;

    // Horizontal timing in panel ticks.
    localparam int H_ACTIVE = 800;
    localparam int H_FRONT = 40;
    localparam int H_SYNC = 48;
    localparam int H_BACK = 40;

    // Vertical timing in lines.
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT = 13;
    localparam int V_SYNC = 3;
    localparam int V_BACK = 29;

    // Scan counter width.
    // Holds the full 928 tick line.
    localparam int COORD_BITS = 10;

    // Default pixel FIFO entries.
    localparam int PIXEL_FIFO_DEPTH = 16;

endpackage

`default_nettype wire
